//--- src.f
+incdir+common
common/dma_pkg.sv
common/mst_pkg.sv
common/mst_cmd_if.sv
hw/dma_regs.sv
hw/data_fifo.sv
dma/dma_sequencer.sv
dma/dma_xfer_counter.sv
mst/mst_cmd_fsm.sv
hw/simple_dma.sv
sim/tb_simple_dma.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log for the verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module tb_simple_dma -o tb_simple_dma \
  && { ./obj_dir/tb_simple_dma > sim.log 2>&1 || true; } \
  && ! grep -qF '*** FAILED ***' sim.log \
  && grep -qF '*** PASSED ***' sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

//--- sim/tb_simple_dma.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_params.svh"

module tb_simple_dma
  import dma_pkg::*;
  import mst_pkg::*;
();

  // transfer lengths of this run and the cycle budget they set
  localparam dma_len_t long_len       = 32'd128;
  localparam dma_len_t short_len      = 32'd6;
  localparam int       total_words    = (int'(long_len) + 3) / 4 + (int'(short_len) + 3) / 4;
  localparam int       timeout_cycles = 40 * total_words + 200;

  logic      Bus2IP_Clk;
  logic      rst;
  mst_data_t bus2ip_data;
  dma_ce_t   bus2ip_wrce;
  dma_ce_t   bus2ip_rdce;
  mst_data_t ip2bus_data;
  logic      ip2bus_wrack;
  logic      ip2bus_rdack;
  logic      bus2ip_mst_cmdack;
  logic      bus2ip_mst_cmplt;
  mst_data_t bus2ip_mstrd_d;
  logic      bus2ip_mstrd_src_rdy_n;
  logic      bus2ip_mstwr_dst_rdy_n;
  logic      ip2bus_mstrd_req;
  logic      ip2bus_mstwr_req;
  dma_addr_t ip2bus_mst_addr;
  mst_data_t ip2bus_mstwr_d;

  // scoreboard state of the running transfer
  dma_addr_t cur_src;
  dma_addr_t cur_dst;
  int        rd_count;
  int        wr_count;
  int        rd_since_wr;
  int        batch_switches;
  bit        last_was_rd;
  logic      req_allowed;
  mst_data_t exp_q[$];
  int        cycle_count = 0;

  simple_dma u_dut (
    .Bus2IP_Clk(Bus2IP_Clk), .rst(rst),
    .bus2ip_data(bus2ip_data), .bus2ip_wrce(bus2ip_wrce), .bus2ip_rdce(bus2ip_rdce),
    .ip2bus_data(ip2bus_data), .ip2bus_wrack(ip2bus_wrack), .ip2bus_rdack(ip2bus_rdack),
    .bus2ip_mst_cmdack(bus2ip_mst_cmdack), .bus2ip_mst_cmplt(bus2ip_mst_cmplt),
    .bus2ip_mstrd_d(bus2ip_mstrd_d), .bus2ip_mstrd_src_rdy_n(bus2ip_mstrd_src_rdy_n),
    .bus2ip_mstwr_dst_rdy_n(bus2ip_mstwr_dst_rdy_n),
    .ip2bus_mstrd_req(ip2bus_mstrd_req), .ip2bus_mstwr_req(ip2bus_mstwr_req),
    .ip2bus_mst_addr(ip2bus_mst_addr), .ip2bus_mstwr_d(ip2bus_mstwr_d)
  );

  initial
  begin
    Bus2IP_Clk = 1'b0;
    forever #5 Bus2IP_Clk = ~Bus2IP_Clk;
  end

  // ------------------------------------------------------------
  // run control and error reporting
  // ------------------------------------------------------------
  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic value_error(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    abort_run();
  endtask

  always @(posedge Bus2IP_Clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles)
    begin
      $display("timeout after %0d cycles, the transfer never finished", cycle_count);
      abort_run();
    end
  end

  // acks follow the chip enables in the same cycle
  a_wrack: assert property (@(posedge Bus2IP_Clk) disable iff (rst)
    ip2bus_wrack == (bus2ip_wrce != '0))
    else value_error("write ack does not match the chip enables");
  a_rdack: assert property (@(posedge Bus2IP_Clk) disable iff (rst)
    ip2bus_rdack == (bus2ip_rdce != '0))
    else value_error("read ack does not match the chip enables");
  a_rdata_idle: assert property (@(posedge Bus2IP_Clk) disable iff (rst)
    (bus2ip_rdce == '0) |-> (ip2bus_data == '0))
    else value_error("read data not zero without a read");
  // no master traffic unless a key write started a transfer
  a_req_allowed: assert property (@(posedge Bus2IP_Clk) disable iff (rst)
    (ip2bus_mstrd_req || ip2bus_mstwr_req) |-> req_allowed)
    else value_error("master request without a started transfer");

  // ------------------------------------------------------------
  // slave register access
  // ------------------------------------------------------------
  task automatic drive_edge();
    @(posedge Bus2IP_Clk);
    #1;
  endtask

  function automatic dma_ce_t reg_ce(input int idx);
    // register 0 sits at the msb
    return dma_ce_t'(1) << (`DMA_NUM_REGS - 1 - idx);
  endfunction

  task automatic write_reg(input int idx, input mst_data_t val);
    drive_edge();
    bus2ip_wrce = reg_ce(idx);
    bus2ip_data = val;
    drive_edge();
    bus2ip_wrce = '0;
    bus2ip_data = '0;
  endtask

  task automatic read_reg(input int idx, output mst_data_t val);
    drive_edge();
    bus2ip_rdce = reg_ce(idx);
    // read mux has settled by mid-cycle
    @(negedge Bus2IP_Clk);
    val = ip2bus_data;
    drive_edge();
    bus2ip_rdce = '0;
  endtask

  // ------------------------------------------------------------
  // master bus responder
  // ------------------------------------------------------------
  task automatic serve_request();
    bit        is_rd;
    int        ack_delay;
    int        cmplt_delay;
    mst_data_t word;
    is_rd       = ip2bus_mstrd_req;
    ack_delay   = 1 + int'($urandom % 3);
    cmplt_delay = 1 + int'($urandom % 3);
    // addresses step one word per completed beat
    if (is_rd)
    begin
      assert (ip2bus_mst_addr == cur_src + dma_addr_t'(4 * rd_count))
        else value_error("read address out of sequence");
    end
    else
    begin
      assert (ip2bus_mst_addr == cur_dst + dma_addr_t'(4 * wr_count))
        else value_error("write address out of sequence");
    end
    repeat (ack_delay) drive_edge();
    bus2ip_mst_cmdack = 1'b1;
    drive_edge();
    bus2ip_mst_cmdack = 1'b0;
    repeat (cmplt_delay - 1) drive_edge();
    bus2ip_mst_cmplt = 1'b1;
    if (is_rd)
    begin
      word = $urandom;
      bus2ip_mstrd_d         = word;
      bus2ip_mstrd_src_rdy_n = 1'b0;
      exp_q.push_back(word);
      rd_count    = rd_count + 1;
      rd_since_wr = rd_since_wr + 1;
      last_was_rd = 1'b1;
      assert (rd_since_wr <= `DMA_FIFO_DEPTH)
        else value_error("more reads than the FIFO holds before a write");
    end
    else
    begin
      bus2ip_mstwr_dst_rdy_n = 1'b0;
      #2;
      assert (exp_q.size() != 0)
        else value_error("write completion with no read word outstanding");
      assert (ip2bus_mstwr_d == exp_q[0])
        else value_error("write data is not the oldest read word");
      void'(exp_q.pop_front());
      if (last_was_rd)
        batch_switches = batch_switches + 1;
      last_was_rd = 1'b0;
      rd_since_wr = 0;
      wr_count    = wr_count + 1;
    end
    drive_edge();
    bus2ip_mst_cmplt       = 1'b0;
    bus2ip_mstrd_src_rdy_n = 1'b1;
    bus2ip_mstwr_dst_rdy_n = 1'b1;
    bus2ip_mstrd_d         = '0;
  endtask

  initial
  begin
    forever
    begin
      @(negedge Bus2IP_Clk);
      if (!rst && (ip2bus_mstrd_req || ip2bus_mstwr_req))
        serve_request();
    end
  end

  // ------------------------------------------------------------
  // one programmed transfer with an optional second key while busy
  // ------------------------------------------------------------
  task automatic run_transfer(input dma_addr_t src, input dma_addr_t dst,
                              input dma_len_t len, input bit rekey);
    int        words;
    mst_data_t val;
    words          = (int'(len) + 3) / 4;
    cur_src        = src;
    cur_dst        = dst;
    rd_count       = 0;
    wr_count       = 0;
    rd_since_wr    = 0;
    batch_switches = 0;
    last_was_rd    = 1'b0;
    write_reg(0, mst_data_t'(src));
    write_reg(1, mst_data_t'(dst));
    write_reg(2, mst_data_t'(len));
    read_reg(0, val);
    assert (val == mst_data_t'(src)) else value_error("source register readback");
    read_reg(1, val);
    assert (val == mst_data_t'(dst)) else value_error("destination register readback");
    read_reg(2, val);
    assert (val == mst_data_t'(len)) else value_error("length register readback");
    req_allowed = 1'b1;
    write_reg(3, `DMA_GO_KEY);
    read_reg(3, val);
    assert (val == 32'd1) else value_error("busy not set after the key write");
    if (rekey)
    begin
      // a second key mid-transfer is ignored
      while (rd_count < 3)
        @(posedge Bus2IP_Clk);
      write_reg(3, `DMA_GO_KEY);
    end
    val = 32'd1;
    while (val[0])
      read_reg(3, val);
    req_allowed = 1'b0;
    assert (rd_count == words) else value_error("wrong number of read requests");
    assert (wr_count == words) else value_error("wrong number of write requests");
    assert (exp_q.size() == 0) else value_error("read words left unwritten");
    if (words > `DMA_FIFO_DEPTH)
    begin
      assert (batch_switches >= 2) else value_error("read and write batches did not alternate");
    end
  endtask

  initial
  begin
    mst_data_t val;
    rst                    = 1'b1;
    bus2ip_data            = '0;
    bus2ip_wrce            = '0;
    bus2ip_rdce            = '0;
    bus2ip_mst_cmdack      = 1'b0;
    bus2ip_mst_cmplt       = 1'b0;
    bus2ip_mstrd_d         = '0;
    bus2ip_mstrd_src_rdy_n = 1'b1;
    bus2ip_mstwr_dst_rdy_n = 1'b1;
    req_allowed            = 1'b0;
    void'($urandom(95126));
    repeat (5) @(posedge Bus2IP_Clk);
    #1;
    rst = 1'b0;
    // requests and acks stay low on a quiet bus
    repeat (10) @(posedge Bus2IP_Clk);
    // wrong key starts nothing
    write_reg(3, 32'h0000_005A);
    repeat (20) @(posedge Bus2IP_Clk);
    read_reg(3, val);
    assert (val == '0) else value_error("busy set without the key");
    run_transfer(32'h1000_0000, 32'h2000_0100, long_len, 1'b1);
    run_transfer(32'h0000_3000, 32'h0000_8000, short_len, 1'b0);
    repeat (5) @(posedge Bus2IP_Clk);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/simple_dma.sv
`timescale 1ns/1ps
`default_nettype none

module simple_dma
  import dma_pkg::*;
  import mst_pkg::*;
(
  input  wire logic      Bus2IP_Clk,
  input  wire logic      rst,
  // slave register port
  input  wire mst_data_t bus2ip_data,
  input  wire dma_ce_t   bus2ip_wrce,
  input  wire dma_ce_t   bus2ip_rdce,
  output mst_data_t      ip2bus_data,
  output logic           ip2bus_wrack,
  output logic           ip2bus_rdack,
  // master port
  input  wire logic      bus2ip_mst_cmdack,
  input  wire logic      bus2ip_mst_cmplt,
  input  wire mst_data_t bus2ip_mstrd_d,
  input  wire logic      bus2ip_mstrd_src_rdy_n,
  input  wire logic      bus2ip_mstwr_dst_rdy_n,
  output logic           ip2bus_mstrd_req,
  output logic           ip2bus_mstwr_req,
  output dma_addr_t      ip2bus_mst_addr,
  output mst_data_t      ip2bus_mstwr_d
);

  dma_cfg_t cfg;
  logic     start;
  logic     busy;
  logic     xfer_load;
  logic     len_zero;
  logic     fifo_full;
  logic     fifo_empty;
  logic     fifo_push;
  logic     fifo_pop;

  mst_cmd_if u_cmd_if ();

  // a key write during a transfer must not restart the counters
  assign xfer_load = start && !busy;

  // read beats land in the FIFO, write beats leave it
  assign fifo_push = !bus2ip_mstrd_src_rdy_n;
  assign fifo_pop  = !bus2ip_mstwr_dst_rdy_n;

  dma_regs u_regs (
    .Bus2IP_Clk(Bus2IP_Clk), .rst(rst),
    .bus2ip_data(bus2ip_data), .bus2ip_wrce(bus2ip_wrce), .bus2ip_rdce(bus2ip_rdce),
    .busy(busy), .ip2bus_data(ip2bus_data),
    .ip2bus_wrack(ip2bus_wrack), .ip2bus_rdack(ip2bus_rdack),
    .cfg(cfg), .start(start)
  );

  dma_sequencer u_seq (
    .Bus2IP_Clk(Bus2IP_Clk), .rst(rst), .start(start),
    .fifo_full(fifo_full), .fifo_empty(fifo_empty), .len_zero(len_zero),
    .busy(busy), .cmd(u_cmd_if.seq)
  );

  dma_xfer_counter u_ctr (
    .Bus2IP_Clk(Bus2IP_Clk), .rst(rst), .start(xfer_load), .cfg(cfg),
    .len_zero(len_zero), .cmd(u_cmd_if.ctr)
  );

  mst_cmd_fsm u_cmd (
    .Bus2IP_Clk(Bus2IP_Clk), .rst(rst), .cmd(u_cmd_if.cmd),
    .bus2ip_mst_cmdack(bus2ip_mst_cmdack), .bus2ip_mst_cmplt(bus2ip_mst_cmplt),
    .mstrd_req(ip2bus_mstrd_req), .mstwr_req(ip2bus_mstwr_req),
    .mst_addr(ip2bus_mst_addr)
  );

  data_fifo u_fifo (
    .Bus2IP_Clk(Bus2IP_Clk), .rst(rst),
    .push(fifo_push), .din(bus2ip_mstrd_d),
    .pop(fifo_pop), .dout(ip2bus_mstwr_d),
    .full(fifo_full), .empty(fifo_empty)
  );

endmodule

`default_nettype wire

//--- mst/mst_cmd_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mst_cmd_fsm
  import dma_pkg::*;
  import mst_pkg::*;
(
  input  wire logic Bus2IP_Clk,
  input  wire logic rst,
  mst_cmd_if.cmd    cmd,
  input  wire logic bus2ip_mst_cmdack,
  input  wire logic bus2ip_mst_cmplt,
  output logic      mstrd_req,
  output logic      mstwr_req,
  output dma_addr_t mst_addr
);

  cmd_state_t state_q;

  // ----------------------------------------------------------
  // state and request lines
  // ----------------------------------------------------------
  always_ff @(posedge Bus2IP_Clk)
  begin
    if (rst)
    begin
      state_q   <= CMD_IDLE;
      mstrd_req <= 1'b0;
      mstwr_req <= 1'b0;
    end
    else
    begin
      case (state_q)
        CMD_IDLE:
          if (cmd.go)
          begin
            // request goes out the cycle after go
            state_q   <= CMD_RUN;
            mstrd_req <= cmd.rd;
            mstwr_req <= !cmd.rd;
          end
        CMD_RUN:
          // cmplt may arrive with or without a separate cmdack
          if (bus2ip_mst_cmplt)
          begin
            state_q   <= CMD_DONE;
            mstrd_req <= 1'b0;
            mstwr_req <= 1'b0;
          end
          else if (bus2ip_mst_cmdack)
          begin
            state_q   <= CMD_WAIT;
            mstrd_req <= 1'b0;
            mstwr_req <= 1'b0;
          end
        CMD_WAIT:
          if (bus2ip_mst_cmplt)
            state_q <= CMD_DONE;
        CMD_DONE:
          // one cycle of done, then ready again
          state_q <= CMD_IDLE;
        default:
          state_q <= CMD_IDLE;
      endcase
    end
  end

  // address is captured with the command and held through the transfer
  always_ff @(posedge Bus2IP_Clk)
  begin
    if (state_q == CMD_IDLE && cmd.go)
      mst_addr <= cmd.addr;
  end

  assign cmd.ready = (state_q == CMD_IDLE);
  assign cmd.done  = (state_q == CMD_DONE);

  // single-beat master, one direction at a time
  a_req_excl: assert property (@(posedge Bus2IP_Clk) disable iff (rst)
    !(mstrd_req && mstwr_req));

endmodule

`default_nettype wire

//--- dma/dma_xfer_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_params.svh"

module dma_xfer_counter
  import dma_pkg::*;
(
  input  wire logic     Bus2IP_Clk,
  input  wire logic     rst,
  input  wire logic     start,
  input  wire dma_cfg_t cfg,
  output logic          len_zero,
  mst_cmd_if.ctr        cmd
);

  // working copies, the programmed values stay readable in the regs
  dma_addr_t src_q;
  dma_addr_t dst_q;
  dma_len_t  remain_q;

  always_ff @(posedge Bus2IP_Clk)
  begin
    if (rst)
    begin
      src_q    <= '0;
      dst_q    <= '0;
      remain_q <= '0;
    end
    else if (start)
    begin
      src_q    <= cfg.src;
      dst_q    <= cfg.dst;
      remain_q <= cfg.len;
    end
    else if (cmd.done)
    begin
      if (cmd.rd)
      begin
        src_q <= src_q + dma_addr_t'(`DMA_WORD_BYTES);
        // a partial last word still moves a full word, clamp at zero
        if (remain_q > dma_len_t'(`DMA_WORD_BYTES))
          remain_q <= remain_q - dma_len_t'(`DMA_WORD_BYTES);
        else
          remain_q <= '0;
      end
      else
      begin
        dst_q <= dst_q + dma_addr_t'(`DMA_WORD_BYTES);
      end
    end
  end

  // address for the next command follows its direction
  assign cmd.addr = cmd.rd ? src_q : dst_q;
  assign len_zero = (remain_q == '0);

endmodule

`default_nettype wire

//--- dma/dma_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module dma_sequencer
  import dma_pkg::*;
(
  input  wire logic  Bus2IP_Clk,
  input  wire logic  rst,
  input  wire logic  start,
  input  wire logic  fifo_full,
  input  wire logic  fifo_empty,
  input  wire logic  len_zero,
  output logic       busy,
  mst_cmd_if.seq     cmd
);

  seq_state_t state_q;
  logic       go_q;
  logic       rd_q;

  // ----------------------------------------------------------
  // read batch until FIFO full or no bytes left,
  // then write batch until FIFO empty, repeat
  // ----------------------------------------------------------
  always_ff @(posedge Bus2IP_Clk)
  begin
    if (rst)
    begin
      state_q <= SEQ_IDLE;
      go_q    <= 1'b0;
      rd_q    <= 1'b0;
    end
    else
    begin
      // go is a single-cycle strobe
      go_q <= 1'b0;
      case (state_q)
        SEQ_IDLE:
          // start outside idle is dropped here
          if (start)
            state_q <= SEQ_RD_CHECK;
        SEQ_RD_CHECK:
          if (fifo_full || len_zero)
            state_q <= SEQ_WR_CHECK;
          else if (cmd.ready)
          begin
            go_q    <= 1'b1;
            rd_q    <= 1'b1;
            state_q <= SEQ_RD_WAIT;
          end
        SEQ_RD_WAIT:
          // counter and FIFO have both stepped by the time done is seen
          if (cmd.done)
            state_q <= SEQ_RD_CHECK;
        SEQ_WR_CHECK:
          if (fifo_empty)
          begin
            if (len_zero)
              state_q <= SEQ_IDLE;
            else
              state_q <= SEQ_RD_CHECK;
          end
          else if (cmd.ready)
          begin
            go_q    <= 1'b1;
            rd_q    <= 1'b0;
            state_q <= SEQ_WR_WAIT;
          end
        SEQ_WR_WAIT:
          if (cmd.done)
            state_q <= SEQ_WR_CHECK;
        default:
          state_q <= SEQ_IDLE;
      endcase
    end
  end

  // rd holds from go until the next go, the counter reads it on done
  assign cmd.go  = go_q;
  assign cmd.rd  = rd_q;
  assign busy    = (state_q != SEQ_IDLE);

  // command FSM takes a go only while it is idle
  a_go_ready: assert property (@(posedge Bus2IP_Clk) disable iff (rst) cmd.go |-> cmd.ready);

endmodule

`default_nettype wire

//--- hw/data_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_params.svh"

module data_fifo
  import mst_pkg::*;
#(
  parameter int depth = `DMA_FIFO_DEPTH
)
(
  input  wire logic      Bus2IP_Clk,
  input  wire logic      rst,
  input  wire logic      push,
  input  wire mst_data_t din,
  input  wire logic      pop,
  output mst_data_t      dout,
  output logic           full,
  output logic           empty
);

  // depth is a power of two, so pointers wrap on their own
  localparam int ptr_w = $clog2(depth);

  mst_data_t        mem [depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  // one extra bit so a full buffer is told apart from an empty one
  logic [ptr_w:0]   count_q;

  // storage only
  always_ff @(posedge Bus2IP_Clk)
  begin
    if (push)
      mem[wr_ptr_q] <= din;
  end

  always_ff @(posedge Bus2IP_Clk)
  begin
    if (rst)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      // push and pop together leave the count alone
      if (push && !pop)
        count_q <= count_q + 1'b1;
      else if (pop && !push)
        count_q <= count_q - 1'b1;
    end
  end

  // head word shows without a pop, write data path reads it directly
  assign dout  = mem[rd_ptr_q];
  assign full  = (count_q == (ptr_w+1)'(depth));
  assign empty = (count_q == '0);

  // read batches stop at full and writes only run while not empty
  a_no_overflow:  assert property (@(posedge Bus2IP_Clk) disable iff (rst) push |-> !full);
  a_no_underflow: assert property (@(posedge Bus2IP_Clk) disable iff (rst) pop |-> !empty);

endmodule

`default_nettype wire

//--- hw/dma_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_params.svh"

module dma_regs
  import dma_pkg::*;
  import mst_pkg::*;
(
  input  wire logic      Bus2IP_Clk,
  input  wire logic      rst,
  input  wire mst_data_t bus2ip_data,
  input  wire dma_ce_t   bus2ip_wrce,
  input  wire dma_ce_t   bus2ip_rdce,
  input  wire logic      busy,
  output mst_data_t      ip2bus_data,
  output logic           ip2bus_wrack,
  output logic           ip2bus_rdack,
  output dma_cfg_t       cfg,
  output logic           start
);

  // register selects, reg 0 on the msb of the chip enables
  localparam dma_ce_t ce_src = dma_ce_t'(1) << (`DMA_NUM_REGS - 1);
  localparam dma_ce_t ce_dst = dma_ce_t'(1) << (`DMA_NUM_REGS - 2);
  localparam dma_ce_t ce_len = dma_ce_t'(1) << (`DMA_NUM_REGS - 3);
  localparam dma_ce_t ce_go  = dma_ce_t'(1) << (`DMA_NUM_REGS - 4);

  // ----------------------------------------------------------
  // register writes
  // ----------------------------------------------------------
  always_ff @(posedge Bus2IP_Clk)
  begin
    if (rst)
    begin
      cfg   <= '0;
      start <= 1'b0;
    end
    else
    begin
      // strobe in the cycle after the key write
      start <= (bus2ip_wrce == ce_go) && (bus2ip_data == mst_data_t'(`DMA_GO_KEY));
      case (bus2ip_wrce)
        ce_src: cfg.src <= dma_addr_t'(bus2ip_data);
        ce_dst: cfg.dst <= dma_addr_t'(bus2ip_data);
        ce_len: cfg.len <= dma_len_t'(bus2ip_data);
        default: ;
      endcase
    end
  end

  // ----------------------------------------------------------
  // read mux and acks, all same-cycle
  // ----------------------------------------------------------
  always_comb
  begin
    case (bus2ip_rdce)
      ce_src: ip2bus_data = mst_data_t'(cfg.src);
      ce_dst: ip2bus_data = mst_data_t'(cfg.dst);
      ce_len: ip2bus_data = mst_data_t'(cfg.len);
      // go register reads back engine status
      ce_go:  ip2bus_data = {{(`DMA_DATA_W-1){1'b0}}, busy};
      default: ip2bus_data = '0;
    endcase
  end

  assign ip2bus_wrack = |bus2ip_wrce;
  assign ip2bus_rdack = |bus2ip_rdce;

  // the bus decoder selects at most one register per access
  a_ce_onehot: assert property (@(posedge Bus2IP_Clk) disable iff (rst)
    $onehot0(bus2ip_wrce) && $onehot0(bus2ip_rdce) && !(|bus2ip_wrce && |bus2ip_rdce));

endmodule

`default_nettype wire

//--- common/mst_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

// one master command, from the sequencer and counter to the command FSM
interface mst_cmd_if
  import dma_pkg::*;
();

  // one-cycle strobe, only while ready
  logic      go;
  // high for a read from src, low for a write to dst
  logic      rd;
  // address of the command, picked by rd in the counter
  dma_addr_t addr;
  // command FSM is idle
  logic      ready;
  // one-cycle strobe, exactly one per go
  logic      done;

  modport seq (output go, output rd, input ready, input done);
  modport ctr (input rd, input done, output addr);
  modport cmd (input go, input rd, input addr, output ready, output done);

endinterface

`default_nettype wire

//--- common/mst_pkg.sv
`default_nettype none

`include "dma_params.svh"

package mst_pkg;

  // one data beat on the master read or write path
  typedef logic [`DMA_DATA_W-1:0] mst_data_t;

  // single-beat command machine
  // idle -> run (request out) -> wait (acked, no cmplt yet) -> done
  typedef enum logic [1:0] {
    CMD_IDLE,
    CMD_RUN,
    CMD_WAIT,
    CMD_DONE
  } cmd_state_t;

endpackage

`default_nettype wire

//--- common/dma_pkg.sv
`default_nettype none

`include "dma_params.svh"

package dma_pkg;

  // byte address on the master side
  typedef logic [`DMA_ADDR_W-1:0] dma_addr_t;

  // byte count, programmed and remaining
  typedef logic [31:0] dma_len_t;

  // one-hot register select, register 0 sits at the msb
  typedef logic [`DMA_NUM_REGS-1:0] dma_ce_t;

  // what software programs before writing the key
  typedef struct packed {
    dma_addr_t src;
    dma_addr_t dst;
    dma_len_t  len;
  } dma_cfg_t;

  // batch sequencer states
  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_RD_CHECK,
    SEQ_RD_WAIT,
    SEQ_WR_CHECK,
    SEQ_WR_WAIT
  } seq_state_t;

endpackage

`default_nettype wire

//--- common/dma_params.svh
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// ------------------------------------------------------------
// bus widths
// ------------------------------------------------------------
`define DMA_DATA_W 32
`define DMA_ADDR_W 32

// number of software registers on the slave side
`define DMA_NUM_REGS 4

// words held between a read batch and its write batch
`define DMA_FIFO_DEPTH 16

// address step per single-beat transfer
`define DMA_WORD_BYTES 4

// value software writes to the go register to start a transfer
`define DMA_GO_KEY 32'h0000_00CC

`endif
